// ==== list.f ====
+incdir+.
spu_data_pkg.sv
spu_isa_pkg.sv
spu_decode.sv
spu_lane_unit.sv
spu_execute.sv
spu_result.sv
spu_fixed_unit.sv
tb_spu_fixed_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fixed-point pipe testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_spu_fixed_unit -o sim_spu
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_spu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1

// ==== spu_data_pkg.sv ====
package spu_data_pkg;

	localparam int vec_width      = 128;
	localparam int reg_addr_width = 7;

	typedef logic [vec_width-1:0]      vec_t;       // lane 0 sits in the top bits
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	typedef logic [7:0]  byte_lane_t;
	typedef logic [15:0] half_lane_t;
	typedef logic [31:0] word_lane_t;

	localparam int byte_lanes = vec_width / $bits(byte_lane_t);   // 16
	localparam int half_lanes = vec_width / $bits(half_lane_t);   // 8
	localparam int word_lanes = vec_width / $bits(word_lane_t);   // 4

	// what the writeback stage receives every cycle
	typedef struct packed {
		vec_t      value;   // result vector
		reg_addr_t addr;    // destination register
		logic      write;   // commit to the register file
	} wb_t;

endpackage

// ==== spu_decode.sv ====
module spu_decode (
	input  logic [2:0]             format,
	input  spu_isa_pkg::op_field_t op,
	input  spu_data_pkg::vec_t     rb,
	input  spu_isa_pkg::imm_t      imm,
	output spu_isa_pkg::decoded_t  dec
);

	logic [spu_isa_pkg::imm10_width-1:0] imm10;
	spu_data_pkg::byte_lane_t            imm_byte;
	spu_data_pkg::half_lane_t            imm_half;
	spu_data_pkg::word_lane_t            imm_word;

	assign imm10    = imm[spu_isa_pkg::imm10_width-1:0];
	assign imm_byte = imm[$bits(imm_byte)-1:0];                         // byte forms drop the top two bits
	assign imm_half = spu_data_pkg::half_lane_t'($signed(imm10));     // sign extended
	assign imm_word = spu_data_pkg::word_lane_t'($signed(imm10));

	function automatic spu_isa_pkg::decoded_t hit(spu_isa_pkg::alu_op_e alu_op,
		spu_isa_pkg::lane_size_e lane_size);
		spu_isa_pkg::decoded_t d;
		d           = '0;
		d.valid     = 1'b1;
		d.alu_op    = alu_op;
		d.lane_size = lane_size;
		return d;
	endfunction

	always_comb begin
		dec = '0;
		if (format == spu_isa_pkg::fmt_rr) begin
			case (op)
				spu_isa_pkg::op_ah:    dec = hit(spu_isa_pkg::alu_add, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_a:     dec = hit(spu_isa_pkg::alu_add, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_sfh:   dec = hit(spu_isa_pkg::alu_sub_from, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_sf:    dec = hit(spu_isa_pkg::alu_sub_from, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_and:   dec = hit(spu_isa_pkg::alu_and, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_or:    dec = hit(spu_isa_pkg::alu_or, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_xor:   dec = hit(spu_isa_pkg::alu_xor, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_nand:  dec = hit(spu_isa_pkg::alu_nand, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_ceqb:  dec = hit(spu_isa_pkg::alu_ceq, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_ceqh:  dec = hit(spu_isa_pkg::alu_ceq, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_ceq:   dec = hit(spu_isa_pkg::alu_ceq, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_cgtb:  dec = hit(spu_isa_pkg::alu_cgt, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_cgth:  dec = hit(spu_isa_pkg::alu_cgt, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_cgt:   dec = hit(spu_isa_pkg::alu_cgt, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_clgtb: dec = hit(spu_isa_pkg::alu_clgt, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_clgth: dec = hit(spu_isa_pkg::alu_clgt, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_clgt:  dec = hit(spu_isa_pkg::alu_clgt, spu_isa_pkg::lane_word);
				default:               dec = '0;   // nop lands here too
			endcase
			dec.b = rb;
		end else if (format == spu_isa_pkg::fmt_ri10) begin
			case (op)
				spu_isa_pkg::op_ahi:    dec = hit(spu_isa_pkg::alu_add, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_ai:     dec = hit(spu_isa_pkg::alu_add, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_sfhi:   dec = hit(spu_isa_pkg::alu_sub_from, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_sfi:    dec = hit(spu_isa_pkg::alu_sub_from, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_andbi:  dec = hit(spu_isa_pkg::alu_and, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_andhi:  dec = hit(spu_isa_pkg::alu_and, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_andi:   dec = hit(spu_isa_pkg::alu_and, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_orbi:   dec = hit(spu_isa_pkg::alu_or, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_orhi:   dec = hit(spu_isa_pkg::alu_or, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_ori:    dec = hit(spu_isa_pkg::alu_or, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_xorbi:  dec = hit(spu_isa_pkg::alu_xor, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_xorhi:  dec = hit(spu_isa_pkg::alu_xor, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_xori:   dec = hit(spu_isa_pkg::alu_xor, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_ceqbi:  dec = hit(spu_isa_pkg::alu_ceq, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_ceqhi:  dec = hit(spu_isa_pkg::alu_ceq, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_ceqi:   dec = hit(spu_isa_pkg::alu_ceq, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_cgtbi:  dec = hit(spu_isa_pkg::alu_cgt, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_cgthi:  dec = hit(spu_isa_pkg::alu_cgt, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_cgti:   dec = hit(spu_isa_pkg::alu_cgt, spu_isa_pkg::lane_word);
				spu_isa_pkg::op_clgtbi: dec = hit(spu_isa_pkg::alu_clgt, spu_isa_pkg::lane_byte);
				spu_isa_pkg::op_clgthi: dec = hit(spu_isa_pkg::alu_clgt, spu_isa_pkg::lane_half);
				spu_isa_pkg::op_clgti:  dec = hit(spu_isa_pkg::alu_clgt, spu_isa_pkg::lane_word);
				default:                dec = '0;
			endcase
			// immediate replicated into every lane of the decoded size
			case (dec.lane_size)
				spu_isa_pkg::lane_byte: dec.b = {spu_data_pkg::byte_lanes{imm_byte}};
				spu_isa_pkg::lane_half: dec.b = {spu_data_pkg::half_lanes{imm_half}};
				default:                dec.b = {spu_data_pkg::word_lanes{imm_word}};
			endcase
		end
	end

endmodule

// ==== spu_execute.sv ====
module spu_execute (
	input  spu_data_pkg::vec_t    a,
	input  spu_isa_pkg::decoded_t dec,
	output spu_data_pkg::vec_t    result
);

	// ascending index puts lane 0 in the top bits of the vector
	spu_data_pkg::byte_lane_t [0:spu_data_pkg::byte_lanes-1] a_byte, b_byte, y_byte;
	spu_data_pkg::half_lane_t [0:spu_data_pkg::half_lanes-1] a_half, b_half, y_half;
	spu_data_pkg::word_lane_t [0:spu_data_pkg::word_lanes-1] a_word, b_word, y_word;

	assign a_byte = a;
	assign b_byte = dec.b;
	assign a_half = a;
	assign b_half = dec.b;
	assign a_word = a;
	assign b_word = dec.b;

	for (genvar i = 0; i < spu_data_pkg::byte_lanes; i++) begin : g_byte
		spu_lane_unit #(.lane_t(spu_data_pkg::byte_lane_t)) u_lane (
			.a      (a_byte[i]),
			.b      (b_byte[i]),
			.alu_op (dec.alu_op),
			.y      (y_byte[i])
		);
	end

	for (genvar i = 0; i < spu_data_pkg::half_lanes; i++) begin : g_half
		spu_lane_unit #(.lane_t(spu_data_pkg::half_lane_t)) u_lane (
			.a      (a_half[i]),
			.b      (b_half[i]),
			.alu_op (dec.alu_op),
			.y      (y_half[i])
		);
	end

	for (genvar i = 0; i < spu_data_pkg::word_lanes; i++) begin : g_word
		spu_lane_unit #(.lane_t(spu_data_pkg::word_lane_t)) u_lane (
			.a      (a_word[i]),
			.b      (b_word[i]),
			.alu_op (dec.alu_op),
			.y      (y_word[i])
		);
	end

	always_comb begin
		case (dec.lane_size)
			spu_isa_pkg::lane_byte: result = y_byte;
			spu_isa_pkg::lane_half: result = y_half;
			spu_isa_pkg::lane_word: result = y_word;
			default:                result = '0;   // unused encoding
		endcase
	end

endmodule

// ==== spu_fixed_unit.sv ====
module spu_fixed_unit (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [2:0]              format,
	input  spu_isa_pkg::op_field_t  op,
	input  spu_data_pkg::reg_addr_t rt_addr,
	input  spu_data_pkg::vec_t      ra,
	input  spu_data_pkg::vec_t      rb,
	input  spu_isa_pkg::imm_t       imm,
	input  logic                    reg_write,
	input  logic                    branch_taken,
	output spu_data_pkg::wb_t       wb
);

	spu_isa_pkg::decoded_t dec;
	spu_data_pkg::vec_t    result;
	logic                  kill;

	assign kill = branch_taken | ~dec.valid;   // wrong path or nothing to execute

	spu_decode u_decode (
		.format (format),
		.op     (op),
		.rb     (rb),
		.imm    (imm),
		.dec    (dec)
	);

	spu_execute u_execute (
		.a      (ra),
		.dec    (dec),
		.result (result)
	);

	spu_result u_result (
		.clk       (clk),
		.reset     (reset),
		.result    (result),
		.rt_addr   (rt_addr),
		.reg_write (reg_write),
		.kill      (kill),
		.wb        (wb)
	);

endmodule

// ==== spu_isa_pkg.sv ====
package spu_isa_pkg;

	localparam logic [2:0] fmt_rr   = 3'd0;
	localparam logic [2:0] fmt_ri10 = 3'd4;

	typedef logic [10:0] op_field_t;   // ri10 opcodes use the low 8 bits
	typedef logic [17:0] imm_t;

	localparam int imm10_width = 10;

	// rr opcodes
	localparam op_field_t op_ah    = 11'b00011001000;
	localparam op_field_t op_a     = 11'b00011000000;
	localparam op_field_t op_sfh   = 11'b00001001000;
	localparam op_field_t op_sf    = 11'b00001000000;
	localparam op_field_t op_and   = 11'b00011000001;
	localparam op_field_t op_or    = 11'b00001000001;
	localparam op_field_t op_xor   = 11'b01001000001;
	localparam op_field_t op_nand  = 11'b00011001001;
	localparam op_field_t op_ceqb  = 11'b01111010000;
	localparam op_field_t op_ceqh  = 11'b01111001000;
	localparam op_field_t op_ceq   = 11'b01111000000;
	localparam op_field_t op_cgtb  = 11'b01001010000;
	localparam op_field_t op_cgth  = 11'b01001001000;
	localparam op_field_t op_cgt   = 11'b01001000000;
	localparam op_field_t op_clgtb = 11'b01011010000;
	localparam op_field_t op_clgth = 11'b01011001000;
	localparam op_field_t op_clgt  = 11'b01011000000;

	// ri10 opcodes keep the top three bits zero
	localparam op_field_t op_ahi    = {3'b000, 8'b00011101};
	localparam op_field_t op_ai     = {3'b000, 8'b00011100};
	localparam op_field_t op_sfhi   = {3'b000, 8'b00001101};
	localparam op_field_t op_sfi    = {3'b000, 8'b00001100};
	localparam op_field_t op_andbi  = {3'b000, 8'b00010110};
	localparam op_field_t op_andhi  = {3'b000, 8'b00010101};
	localparam op_field_t op_andi   = {3'b000, 8'b00010100};
	localparam op_field_t op_orbi   = {3'b000, 8'b00000110};
	localparam op_field_t op_orhi   = {3'b000, 8'b00000101};
	localparam op_field_t op_ori    = {3'b000, 8'b00000100};
	localparam op_field_t op_xorbi  = {3'b000, 8'b01000110};
	localparam op_field_t op_xorhi  = {3'b000, 8'b01000101};
	localparam op_field_t op_xori   = {3'b000, 8'b01000100};
	localparam op_field_t op_ceqbi  = {3'b000, 8'b01111110};
	localparam op_field_t op_ceqhi  = {3'b000, 8'b01111101};
	localparam op_field_t op_ceqi   = {3'b000, 8'b01111100};
	localparam op_field_t op_cgtbi  = {3'b000, 8'b01001110};
	localparam op_field_t op_cgthi  = {3'b000, 8'b01001101};
	localparam op_field_t op_cgti   = {3'b000, 8'b01001100};
	localparam op_field_t op_clgtbi = {3'b000, 8'b01011110};
	localparam op_field_t op_clgthi = {3'b000, 8'b01011101};
	localparam op_field_t op_clgti  = {3'b000, 8'b01011100};

	typedef enum logic [3:0] {
		alu_add, alu_sub_from, alu_and, alu_or, alu_xor, alu_nand, alu_ceq, alu_cgt, alu_clgt
	} alu_op_e;

	typedef enum logic [1:0] {
		lane_byte, lane_half, lane_word
	} lane_size_e;

	typedef struct packed {
		logic                valid;       // low for nop and unknown encodings
		alu_op_e             alu_op;
		lane_size_e          lane_size;
		spu_data_pkg::vec_t  b;           // rb or the expanded immediate
	} decoded_t;

endpackage

// ==== spu_lane_unit.sv ====
module spu_lane_unit #(
	parameter type lane_t = logic [7:0]
) (
	input  lane_t                a,
	input  lane_t                b,
	input  spu_isa_pkg::alu_op_e alu_op,
	output lane_t                y
);

	localparam int w = $bits(lane_t);

	logic signed [w:0] sum;    // one guard bit for overflow detection
	logic signed [w:0] diff;

	assign sum  = $signed({a[w-1], a}) + $signed({b[w-1], b});
	assign diff = $signed({b[w-1], b}) - $signed({a[w-1], a});   // subtract from is b - a

	// clamp to the signed range when the guard bit disagrees with the sign
	function automatic lane_t saturate(logic signed [w:0] v);
		lane_t r;
		if (v[w] != v[w-1])
			r = v[w] ? {1'b1, {(w-1){1'b0}}} : {1'b0, {(w-1){1'b1}}};
		else
			r = v[w-1:0];
		return r;
	endfunction

	always_comb begin
		case (alu_op)
			spu_isa_pkg::alu_add:      y = saturate(sum);
			spu_isa_pkg::alu_sub_from: y = saturate(diff);
			spu_isa_pkg::alu_and:      y = a & b;
			spu_isa_pkg::alu_or:       y = a | b;
			spu_isa_pkg::alu_xor:      y = a ^ b;
			spu_isa_pkg::alu_nand:     y = ~(a & b);
			spu_isa_pkg::alu_ceq:      y = {w{a == b}};                 // all ones when true
			spu_isa_pkg::alu_cgt:      y = {w{$signed(a) > $signed(b)}};
			spu_isa_pkg::alu_clgt:     y = {w{a > b}};
			default:                   y = '0;
		endcase
	end

endmodule

// ==== spu_result.sv ====
module spu_result (
	input  logic                    clk,
	input  logic                    reset,
	input  spu_data_pkg::vec_t      result,
	input  spu_data_pkg::reg_addr_t rt_addr,
	input  logic                    reg_write,
	input  logic                    kill,
	output spu_data_pkg::wb_t       wb
);

	// single stage between execute and writeback
	always_ff @(posedge clk) begin
		if (reset || kill) begin
			wb <= '0;   // squashed slot never writes
		end else begin
			wb.value <= result;
			wb.addr  <= rt_addr;
			wb.write <= reg_write;
		end
	end

endmodule

// ==== tb_spu_model.svh ====
`ifndef tb_spu_model_svh
`define tb_spu_model_svh

// operation kinds as the model sees them
localparam int k_add  = 0;
localparam int k_sub  = 1;   // b minus a
localparam int k_and  = 2;
localparam int k_or   = 3;
localparam int k_xor  = 4;
localparam int k_nand = 5;
localparam int k_ceq  = 6;
localparam int k_cgt  = 7;
localparam int k_clgt = 8;
localparam int k_none = 9;   // nop, unknown opcode or dropped format

logic [31:0] rng_state;

// one row per encoding where width 0 marks one that must be squashed
logic [2:0]             enc_fmt[$];
spu_isa_pkg::op_field_t enc_op[$];
int                     enc_kind[$];
int                     enc_width[$];
bit                     enc_imm[$];

function automatic logic [31:0] lcg_step();
	rng_state = rng_state * 32'd1103515245 + 32'd12345;
	return rng_state;
endfunction

// low bits of an lcg are weak so only the upper halves are kept
function automatic logic [31:0] rand32();
	logic [31:0] hi;
	logic [31:0] lo;
	hi = lcg_step();
	lo = lcg_step();
	return {hi[31:16], lo[31:16]};
endfunction

task automatic add_enc(logic [2:0] fmt, spu_isa_pkg::op_field_t op, int kind, int w, bit imm_form);
	enc_fmt.push_back(fmt);
	enc_op.push_back(op);
	enc_kind.push_back(kind);
	enc_width.push_back(w);
	enc_imm.push_back(imm_form);
endtask

task automatic build_tables();
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_ah, k_add, 16, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_a, k_add, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_sfh, k_sub, 16, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_sf, k_sub, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_and, k_and, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_or, k_or, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_xor, k_xor, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_nand, k_nand, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_ceqb, k_ceq, 8, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_ceqh, k_ceq, 16, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_ceq, k_ceq, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_cgtb, k_cgt, 8, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_cgth, k_cgt, 16, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_cgt, k_cgt, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_clgtb, k_clgt, 8, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_clgth, k_clgt, 16, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_clgt, k_clgt, 32, 1'b0);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_ahi, k_add, 16, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_ai, k_add, 32, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_sfhi, k_sub, 16, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_sfi, k_sub, 32, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_andbi, k_and, 8, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_andhi, k_and, 16, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_andi, k_and, 32, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_orbi, k_or, 8, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_orhi, k_or, 16, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_ori, k_or, 32, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_xorbi, k_xor, 8, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_xorhi, k_xor, 16, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_xori, k_xor, 32, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_ceqbi, k_ceq, 8, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_ceqhi, k_ceq, 16, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_ceqi, k_ceq, 32, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_cgtbi, k_cgt, 8, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_cgthi, k_cgt, 16, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_cgti, k_cgt, 32, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_clgtbi, k_clgt, 8, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_clgthi, k_clgt, 16, 1'b1);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_clgti, k_clgt, 32, 1'b1);
	// encodings that must give an empty writeback
	add_enc(spu_isa_pkg::fmt_rr, 11'd0, k_none, 0, 1'b0);             // nop
	add_enc(spu_isa_pkg::fmt_rr, 11'h7ff, k_none, 0, 1'b0);
	add_enc(spu_isa_pkg::fmt_rr, spu_isa_pkg::op_ai, k_none, 0, 1'b0);
	add_enc(spu_isa_pkg::fmt_ri10, 11'h0ff, k_none, 0, 1'b0);
	add_enc(spu_isa_pkg::fmt_ri10, spu_isa_pkg::op_ah, k_none, 0, 1'b0);
	add_enc(3'd5, spu_isa_pkg::op_ahi, k_none, 0, 1'b0);              // old immediate loads
	add_enc(3'd6, spu_isa_pkg::op_ai, k_none, 0, 1'b0);
	add_enc(3'd1, spu_isa_pkg::op_a, k_none, 0, 1'b0);
endtask

function automatic logic [31:0] lane_mask(int w);
	return (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
endfunction

// second operand of an immediate form with lane 0 in the top bits
function automatic spu_data_pkg::vec_t imm_operand(int w, spu_isa_pkg::imm_t imm);
	spu_data_pkg::vec_t v;
	logic [31:0]        lane;
	if (w == 8)
		lane = {24'h0, imm[7:0]};
	else
		lane = {{22{imm[9]}}, imm[9:0]} & lane_mask(w);
	v = '0;
	for (int i = 0; i < 128 / w; i++)
		v = (v << w) | spu_data_pkg::vec_t'(lane);
	return v;
endfunction

// one lane worked out with plain integer arithmetic
function automatic logic [31:0] lane_result(int kind, int w, logic [31:0] a, logic [31:0] b);
	longint one;
	longint ua;
	longint ub;
	longint sa;
	longint sb;
	longint r;
	longint hi;
	longint lo;
	one = 1;
	ua  = longint'(a & lane_mask(w));
	ub  = longint'(b & lane_mask(w));
	sa  = (ua >= (one << (w - 1))) ? ua - (one << w) : ua;
	sb  = (ub >= (one << (w - 1))) ? ub - (one << w) : ub;
	hi  = (one << (w - 1)) - one;
	lo  = -(one << (w - 1));
	case (kind)
		k_add:   r = sa + sb;
		k_sub:   r = sb - sa;
		k_and:   r = ua & ub;
		k_or:    r = ua | ub;
		k_xor:   r = ua ^ ub;
		k_nand:  r = ~(ua & ub);
		k_ceq:   r = (ua == ub) ? -one : 0;
		k_cgt:   r = (sa > sb) ? -one : 0;
		k_clgt:  r = (ua > ub) ? -one : 0;
		default: r = 0;
	endcase
	if (kind == k_add || kind == k_sub) begin
		if (r > hi)
			r = hi;
		else if (r < lo)
			r = lo;
	end
	return 32'(r) & lane_mask(w);
endfunction

function automatic spu_data_pkg::vec_t vector_result(int kind, int w, spu_data_pkg::vec_t a,
	spu_data_pkg::vec_t b);
	spu_data_pkg::vec_t y;
	int                 sh;
	y = '0;
	for (int i = 0; i < 128 / w; i++) begin
		sh = 128 - (i + 1) * w;   // lane 0 is the top lane
		y  = y | (spu_data_pkg::vec_t'(lane_result(kind, w, 32'(a >> sh), 32'(b >> sh))) << sh);
	end
	return y;
endfunction

`endif

// ==== tb_spu_fixed_unit.sv ====
module tb_spu_fixed_unit;

	localparam int     reset_cycles = 10;
	localparam int     test_cycles  = 3000;
	localparam longint timeout_time = 2 * (reset_cycles + test_cycles) * 10;

	logic                    clk;
	logic                    reset;
	logic [2:0]              format;
	spu_isa_pkg::op_field_t  op;
	spu_data_pkg::reg_addr_t rt_addr;
	spu_data_pkg::vec_t      ra;
	spu_data_pkg::vec_t      rb;
	spu_isa_pkg::imm_t       imm;
	logic                    reg_write;
	logic                    branch_taken;
	spu_data_pkg::wb_t       wb;

	spu_data_pkg::wb_t expect_q[$];   // one entry per edge still to be seen
	int                cur_idx;
	int                n_checks;
	int                n_errors;

	`include "tb_spu_model.svh"

	spu_fixed_unit dut (
		.clk          (clk),
		.reset        (reset),
		.format       (format),
		.op           (op),
		.rt_addr      (rt_addr),
		.ra           (ra),
		.rb           (rb),
		.imm          (imm),
		.reg_write    (reg_write),
		.branch_taken (branch_taken),
		.wb           (wb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input logic [$bits(spu_data_pkg::wb_t)-1:0] got,
		input logic [$bits(spu_data_pkg::wb_t)-1:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// halfwords pushed towards the signed limits so adds saturate often
	function automatic spu_data_pkg::vec_t rand_vec();
		spu_data_pkg::vec_t v;
		logic [31:0]        r;
		logic [15:0]        h;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			case (r[31:30])
				2'd0:    h = 16'h7ff0 | {12'h0, r[3:0]};
				2'd1:    h = 16'h8000 | {12'h0, r[3:0]};
				default: h = r[15:0];
			endcase
			v = {v[111:0], h};
		end
		return v;
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		r            = rand32();
		cur_idx      = int'(r % 32'(enc_fmt.size()));
		format       = enc_fmt[cur_idx];
		op           = enc_op[cur_idx];
		ra           = rand_vec();
		rb           = rand_vec();
		r            = rand32();
		imm          = r[17:0];
		rt_addr      = r[24:18];
		reg_write    = (r[26:25] != 2'd0);
		branch_taken = (r[29:27] == 3'd0);   // about one in eight
		r            = rand32();
		if (r[2:0] == 3'd0)
			rb = ra;                           // equal operands for the compares
		else if (r[2:0] == 3'd1 && enc_imm[cur_idx])
			ra = imm_operand(enc_width[cur_idx], imm);
	endtask

	function automatic spu_data_pkg::wb_t expected_wb(bit in_reset, int idx);
		spu_data_pkg::wb_t e;
		spu_data_pkg::vec_t b;
		e = '0;
		if (!in_reset && !branch_taken && enc_width[idx] != 0) begin
			b       = enc_imm[idx] ? imm_operand(enc_width[idx], imm) : rb;
			e.value = vector_result(enc_kind[idx], enc_width[idx], ra, b);
			e.addr  = rt_addr;
			e.write = reg_write;
		end
		return e;
	endfunction

	initial begin
		#(timeout_time);
		$display("watchdog expired before the test finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		n_checks     = 0;
		n_errors     = 0;
		cur_idx      = 0;
		rng_state    = 32'd4037;
		reset        = 1'b1;
		format       = 3'd0;
		op           = '0;
		rt_addr      = '0;
		ra           = '0;
		rb           = '0;
		imm          = '0;
		reg_write    = 1'b0;
		branch_taken = 1'b0;
		build_tables();
		expect_q.push_back('0);   // first edge is inside reset
		for (int c = 0; c < reset_cycles + test_cycles; c++) begin
			@(posedge clk);
			#1;
			check_value(wb, expect_q.pop_front(), "writeback");
			if (c == reset_cycles - 1)
				reset = 1'b0;
			drive_random();
			expect_q.push_back(expected_wb(reset, cur_idx));
		end
		@(posedge clk);
		#1;
		check_value(wb, expect_q.pop_front(), "writeback");   // last instruction driven
		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
